// ==== bench/tb_usb_packet.sv ====
/*
 * testbench for the usb device packet handler
 *  - host side token, data and handshake packets on the byte stream
 *  - IN buffer model with one cycle read latency, OUT buffer capture
 *  - reference crc5 and crc16 from the usb polynomials
 *  - assertion checks on responses, buffer writes, commits and flags
 */
`timescale 1ns/1ns

module tb_usb_packet;

	typedef logic [7:0] byte_q_t[$];

	localparam int LEN_W = usb_pkg::LEN_W;
	localparam int NAK_WAIT = 16;
	localparam int PAY_LEN = 12;
	localparam int IN_LEN = 9;
	localparam logic [31:0] SEED = 32'h4c37_6f78;
	localparam logic [6:0] DEV_ADDR = 7'h2b;
	localparam logic [3:0] OUT_ENDP = 4'h3;
	localparam logic [3:0] IN_ENDP = 4'h1;
	// pid bytes as they appear on the wire
	localparam logic [7:0] OUT_B = 8'he1;
	localparam logic [7:0] IN_B = 8'h69;
	localparam logic [7:0] SOF_B = 8'ha5;
	localparam logic [7:0] SETUP_B = 8'h2d;
	localparam logic [7:0] DATA0_B = 8'hc3;
	localparam logic [7:0] DATA1_B = 8'h4b;
	localparam logic [7:0] ACK_B = 8'hd2;
	localparam logic [7:0] NAK_B = 8'h5a;
	// run length estimate, per step a token, a data packet and a reply
	localparam int N_STEPS = 10;
	localparam int TOK_CYC = 2 * 3 + 3;
	localparam int DATA_CYC = 2 * (PAY_LEN + 3) + 3;
	localparam int RESP_CYC = NAK_WAIT + 4 * (PAY_LEN + 3) + 8;
	localparam int STIM_CYC = 8 + N_STEPS * (TOK_CYC + DATA_CYC + RESP_CYC);
	localparam int TIMEOUT_CYC = 4 * STIM_CYC;
	localparam int SILENT_CYC = NAK_WAIT + 16;

	logic phy_clk;
	logic reset_2;
	logic in_act;
	logic [7:0] in_byte;
	logic in_latch;
	logic out_cts = 1'b0;
	logic out_nxt = 1'b0;
	logic [7:0] out_byte;
	logic out_latch;
	logic out_stp;
	logic [3:0] sel_endp;
	logic [usb_pkg::BUF_AW-1:0] buf_in_addr;
	logic [7:0] buf_in_data;
	logic buf_in_wren;
	logic buf_in_ready;
	logic buf_in_commit;
	logic [LEN_W-1:0] buf_in_commit_len;
	logic [LEN_W-1:0] buf_out_addr;
	logic [7:0] buf_out_q;
	logic [LEN_W-1:0] buf_out_len;
	logic buf_out_hasdata;
	logic buf_out_arm;
	logic data_toggle_act;
	usb_pkg::toggle_t data_toggle;
	logic [usb_pkg::ADDR_W-1:0] dev_addr;
	logic err_crc_pid;
	logic err_crc_tok;
	logic err_crc_pkt;
	logic [10:0] frame_num;

	// buffer models and monitor state
	logic [7:0] in_mem [0:2047];
	logic [7:0] out_mem [0:511];
	byte_q_t exp_out;
	byte_q_t tx_q;
	logic wr_allowed = 1'b0;
	logic stall_en = 1'b0;
	int write_count = 0;
	int commit_count = 0;
	int stp_count = 0;
	int arm_count = 0;
	int cycle_cnt = 0;
	logic [LEN_W-1:0] commit_len;

	usb_packet_top #(
		.MAX_PKT_BYTES (512),
		.NAK_WAIT (NAK_WAIT)
	) u_dut (.*);

	initial phy_clk = 1'b0;
	always #20 phy_clk = ~phy_clk;

	task automatic fail_value(input string sig, input int got, input int exp);
		$display("error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, sig, got, exp);
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic fail_msg(input string what);
		$display("%s, at %0t ns", what, $time);
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// serial crc5, lsb first, returned as the inverted field of the second byte
	function automatic logic [4:0] crc5_field(input logic [10:0] d);
		logic [4:0] r;
		logic [4:0] f;
		logic fb;
		r = 5'h1f;
		for (int i = 0; i < 11; i++) begin
			fb = r[4] ^ d[i];
			r = {r[3:0], 1'b0};
			if (fb)
				r = r ^ 5'h05;
		end
		// msb of the register goes out first
		for (int j = 0; j < 5; j++)
			f[j] = ~r[4 - j];
		return f;
	endfunction

	// crc16 as it goes on the wire, low byte first in [7:0]
	function automatic logic [15:0] crc16_wire(input byte_q_t q);
		logic [15:0] r;
		logic [15:0] w;
		logic fb;
		r = 16'hffff;
		foreach (q[i]) begin
			for (int k = 0; k < 8; k++) begin
				fb = r[15] ^ q[i][k];
				r = {r[14:0], 1'b0};
				if (fb)
					r = r ^ 16'h8005;
			end
		end
		for (int j = 0; j < 16; j++)
			w[j] = ~r[15 - j];
		return w;
	endfunction

	function automatic logic [7:0] data_pid_byte(input usb_pkg::toggle_t tog);
		case (tog)
			usb_pkg::TOGGLE_1: return 8'h4b;
			usb_pkg::TOGGLE_2: return 8'h87;
			usb_pkg::TOGGLE_M: return 8'h0f;
			default: return 8'hc3;
		endcase
	endfunction

	// ulpi transmit command for a pid byte
	function automatic logic [7:0] tx_cmd(input logic [7:0] pid_byte);
		return 8'h40 | (pid_byte & 8'h0f);
	endfunction

	// IN buffer, registered read
	always @(posedge phy_clk)
		buf_out_q <= in_mem[buf_out_addr];

	// phy side stalls
	always @(posedge phy_clk) begin
		if (stall_en) begin
			out_nxt <= ($urandom % 2) == 1;
			out_cts <= ($urandom % 4) != 0;
		end else begin
			out_nxt <= 1'b0;
			out_cts <= 1'b0;
		end
	end

	// all outputs observed mid cycle
	always @(negedge phy_clk) begin
		if (buf_in_wren) begin
			write_count++;
			if (int'(buf_in_addr) >= exp_out.size()) begin
				fail_msg("buffer write beyond the payload, a CRC byte was written");
			end else begin
				out_mem[buf_in_addr] = buf_in_data;
				assert (buf_in_data == exp_out[buf_in_addr])
				else fail_value("buf_in_data", int'(buf_in_data), int'(exp_out[buf_in_addr]));
			end
		end
		if (buf_in_commit) begin
			commit_count++;
			commit_len = buf_in_commit_len;
		end
		if (out_latch && out_nxt)
			tx_q.push_back(out_byte);
		if (out_stp)
			stp_count++;
		if (buf_out_arm)
			arm_count++;
	end

	always @(posedge phy_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYC)
			fail_msg("run did not finish within the cycle limit");
	end

	assert property (@(posedge phy_clk) disable iff (!reset_2) buf_in_wren |-> wr_allowed)
	else fail_msg("buffer write where none was expected");

	// release and toggle advance come as one pair
	assert property (@(posedge phy_clk) disable iff (!reset_2)
		buf_out_arm == data_toggle_act)
	else fail_value("data_toggle_act", int'(data_toggle_act), int'(buf_out_arm));

	// one byte latched, then one idle cycle
	task automatic send_packet(input byte_q_t q);
		foreach (q[i]) begin
			@(posedge phy_clk);
			in_act <= 1'b1;
			in_byte <= q[i];
			in_latch <= 1'b1;
			@(posedge phy_clk);
			in_latch <= 1'b0;
		end
		@(posedge phy_clk);
		in_act <= 1'b0;
		repeat (2) @(posedge phy_clk);
	endtask

	task automatic send_token(input logic [7:0] pid_b, input logic [10:0] field, input logic bad);
		logic [4:0] f;
		byte_q_t q;
		f = crc5_field(field);
		if (bad)
			f = f ^ 5'h04;
		q = {};
		q.push_back(pid_b);
		q.push_back(field[7:0]);
		q.push_back({f, field[10:8]});
		send_packet(q);
	endtask

	task automatic send_data(input logic [7:0] pid_b, input byte_q_t pay, input logic bad);
		logic [15:0] crc;
		byte_q_t q;
		crc = crc16_wire(pay);
		if (bad)
			crc = crc ^ 16'h0100;
		q = {};
		q.push_back(pid_b);
		foreach (pay[i])
			q.push_back(pay[i]);
		q.push_back(crc[7:0]);
		q.push_back(crc[15:8]);
		send_packet(q);
	endtask

	task automatic random_payload(output byte_q_t pay, input int len);
		pay = {};
		for (int i = 0; i < len; i++)
			pay.push_back(8'($urandom));
	endtask

	task automatic wait_stp(input int n);
		for (int i = 0; i < 4 * RESP_CYC && stp_count == n; i++)
			@(posedge phy_clk);
		if (stp_count == n)
			fail_msg("no response packet ended with out_stp");
		// let tx_done reach the controller
		repeat (3) @(posedge phy_clk);
	endtask

	task automatic expect_silence(input int cycles);
		repeat (cycles) begin
			@(negedge phy_clk);
			assert (!out_latch) else fail_value("out_latch", int'(out_latch), 0);
		end
		@(posedge phy_clk);
	endtask

	task automatic compare_resp(input byte_q_t exp_q);
		assert (tx_q.size() == exp_q.size())
		else fail_value("response length", tx_q.size(), exp_q.size());
		foreach (exp_q[i])
			assert (tx_q[i] == exp_q[i]) else fail_value("out_byte", int'(tx_q[i]), int'(exp_q[i]));
	endtask

	task automatic check_error_flags(input logic pid_e, input logic tok_e, input logic pkt_e);
		@(negedge phy_clk);
		assert (err_crc_pid == pid_e) else fail_value("err_crc_pid", int'(err_crc_pid), int'(pid_e));
		assert (err_crc_tok == tok_e) else fail_value("err_crc_tok", int'(err_crc_tok), int'(tok_e));
		assert (err_crc_pkt == pkt_e) else fail_value("err_crc_pkt", int'(err_crc_pkt), int'(pkt_e));
	endtask

	// OUT or SETUP with a data packet, ACK and commit when ready, else NAK
	task automatic test_out(input logic [7:0] tok_b, input logic [7:0] dat_b,
		input logic ready, input logic [3:0] endp);
		byte_q_t pay;
		byte_q_t exp_q;
		int n;
		random_payload(pay, PAY_LEN);
		foreach (pay[i])
			out_mem[i] = ~pay[i];
		exp_out = pay;
		wr_allowed = ready;
		write_count = 0;
		commit_count = 0;
		tx_q.delete();
		n = stp_count;
		exp_q = {};
		exp_q.push_back(ready ? tx_cmd(ACK_B) : tx_cmd(NAK_B));
		@(posedge phy_clk);
		buf_in_ready <= ready;
		send_token(tok_b, {endp, DEV_ADDR}, 1'b0);
		@(negedge phy_clk);
		assert (sel_endp == endp) else fail_value("sel_endp", int'(sel_endp), int'(endp));
		send_data(dat_b, pay, 1'b0);
		wait_stp(n);
		compare_resp(exp_q);
		assert (commit_count == int'(ready))
		else fail_value("buf_in_commit count", commit_count, int'(ready));
		assert (write_count == (ready ? PAY_LEN : 0))
		else fail_value("buf_in_wren count", write_count, ready ? PAY_LEN : 0);
		if (ready) begin
			assert (commit_len == LEN_W'(PAY_LEN))
			else fail_value("buf_in_commit_len", int'(commit_len), PAY_LEN);
			for (int i = 0; i < PAY_LEN; i++)
				assert (out_mem[i] == pay[i]) else fail_value("out buffer", int'(out_mem[i]), int'(pay[i]));
		end
		wr_allowed = 1'b0;
	endtask

	// IN token, data with crc from the buffer or NAK, host ACK releases the buffer
	task automatic test_in(input usb_pkg::toggle_t tog, input logic hasdata);
		byte_q_t pay;
		byte_q_t exp_q;
		byte_q_t ack_q;
		logic [15:0] crc;
		int n;
		for (int a = 0; a < 2048; a++)
			in_mem[a] = 8'($urandom);
		pay = {};
		for (int i = 0; i < IN_LEN; i++)
			pay.push_back(in_mem[i]);
		exp_q = {};
		if (hasdata) begin
			crc = crc16_wire(pay);
			exp_q.push_back(tx_cmd(data_pid_byte(tog)));
			foreach (pay[i])
				exp_q.push_back(pay[i]);
			exp_q.push_back(crc[7:0]);
			exp_q.push_back(crc[15:8]);
		end else begin
			exp_q.push_back(tx_cmd(NAK_B));
		end
		@(posedge phy_clk);
		data_toggle <= tog;
		buf_out_hasdata <= hasdata;
		buf_out_len <= LEN_W'(IN_LEN);
		tx_q.delete();
		arm_count = 0;
		n = stp_count;
		send_token(IN_B, {IN_ENDP, DEV_ADDR}, 1'b0);
		wait_stp(n);
		compare_resp(exp_q);
		if (hasdata) begin
			ack_q = {};
			ack_q.push_back(ACK_B);
			send_packet(ack_q);
			for (int i = 0; i < 8 && arm_count == 0; i++)
				@(posedge phy_clk);
			if (arm_count == 0)
				fail_msg("no buf_out_arm after the host ACK");
			repeat (2) @(posedge phy_clk);
		end
		assert (arm_count == int'(hasdata)) else fail_value("buf_out_arm count", arm_count, int'(hasdata));
		buf_out_hasdata <= 1'b0;
	endtask

	task automatic test_sof();
		logic [10:0] frame;
		logic [3:0] endp_before;
		frame = 11'($urandom);
		@(negedge phy_clk);
		endp_before = sel_endp;
		send_token(SOF_B, frame, 1'b0);
		@(negedge phy_clk);
		assert (frame_num == frame) else fail_value("frame_num", int'(frame_num), int'(frame));
		assert (sel_endp == endp_before)
		else fail_value("sel_endp", int'(sel_endp), int'(endp_before));
	endtask

	// OUT plus data for another device, nothing written and no reply
	task automatic test_other_addr();
		byte_q_t pay;
		logic [3:0] endp_before;
		random_payload(pay, PAY_LEN);
		exp_out = pay;
		wr_allowed = 1'b0;
		write_count = 0;
		@(posedge phy_clk);
		buf_in_ready <= 1'b1;
		@(negedge phy_clk);
		endp_before = sel_endp;
		send_token(OUT_B, {4'h5, DEV_ADDR ^ 7'h01}, 1'b0);
		@(negedge phy_clk);
		assert (sel_endp == endp_before)
		else fail_value("sel_endp", int'(sel_endp), int'(endp_before));
		send_data(DATA0_B, pay, 1'b0);
		expect_silence(SILENT_CYC);
		assert (write_count == 0) else fail_value("buf_in_wren count", write_count, 0);
	endtask

	task automatic test_bad_crc16();
		byte_q_t pay;
		random_payload(pay, PAY_LEN);
		// payload still lands in the buffer, only the commit is withheld
		exp_out = pay;
		wr_allowed = 1'b1;
		commit_count = 0;
		@(posedge phy_clk);
		buf_in_ready <= 1'b1;
		send_token(OUT_B, {OUT_ENDP, DEV_ADDR}, 1'b0);
		send_data(DATA1_B, pay, 1'b1);
		expect_silence(SILENT_CYC);
		check_error_flags(1'b0, 1'b0, 1'b1);
		assert (commit_count == 0) else fail_value("buf_in_commit count", commit_count, 0);
		wr_allowed = 1'b0;
	endtask

	task automatic test_bad_crc5();
		@(posedge phy_clk);
		buf_out_hasdata <= 1'b1;
		send_token(IN_B, {IN_ENDP, DEV_ADDR}, 1'b1);
		expect_silence(SILENT_CYC);
		check_error_flags(1'b0, 1'b1, 1'b1);
		@(posedge phy_clk);
		buf_out_hasdata <= 1'b0;
	endtask

	task automatic test_bad_pid();
		byte_q_t q;
		q = {};
		// upper nibble e, lower nibble not its complement
		q.push_back(8'he0);
		q.push_back(8'h12);
		send_packet(q);
		expect_silence(SILENT_CYC);
		check_error_flags(1'b1, 1'b1, 1'b1);
	endtask

	initial begin
		void'($urandom(SEED));
		reset_2 = 1'b0;
		in_act = 1'b0;
		in_byte = 8'h00;
		in_latch = 1'b0;
		buf_in_ready = 1'b0;
		buf_out_len = '0;
		buf_out_hasdata = 1'b0;
		data_toggle = usb_pkg::TOGGLE_0;
		dev_addr = DEV_ADDR;
		repeat (8) @(posedge phy_clk);
		reset_2 <= 1'b1;
		stall_en = 1'b1;
		repeat (2) @(posedge phy_clk);
		check_error_flags(1'b0, 1'b0, 1'b0);
		assert (!out_latch) else fail_value("out_latch", int'(out_latch), 0);
		test_out(OUT_B, DATA0_B, 1'b1, OUT_ENDP);
		test_out(SETUP_B, DATA0_B, 1'b0, 4'h0);
		test_in(usb_pkg::TOGGLE_0, 1'b1);
		test_in(usb_pkg::TOGGLE_1, 1'b1);
		test_in(usb_pkg::TOGGLE_0, 1'b0);
		test_sof();
		test_other_addr();
		// good traffic so far, no flag may be set
		check_error_flags(1'b0, 1'b0, 1'b0);
		test_bad_crc16();
		test_bad_crc5();
		test_bad_pid();
		repeat (4) @(posedge phy_clk);
		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the packet handler testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_usb_packet -f sim.f -o tb_usb_packet
./obj_dir/tb_usb_packet > sim.log 2>&1 || true
cat sim.log
if grep -q '>>> FAIL' sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q '>>> PASS' sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

// ==== sim.f ====
source/usb_pkg.sv
source/usb_crc5.sv
source/usb_crc16.sv
source/usb_rx.sv
source/usb_tx.sv
source/usb_proto_fsm.sv
source/usb_packet_top.sv
bench/tb_usb_packet.sv

// ==== source/usb_crc16.sv ====
/*
 * usb crc16, x^16 + x^15 + x^2 + 1
 * one byte per step, lsb first
 * raw register out, users invert and bit-reverse for the wire
 */
`timescale 1ns/1ns

module usb_crc16 (
	input logic [7:0] data,
	input logic [15:0] crc_in,
	output logic [15:0] crc_out
);

	// eight serial steps flattened
	always_comb begin
		logic [15:0] c;
		logic fb;
		c = crc_in;
		for (int i = 0; i < 8; i++) begin
			fb = c[15] ^ data[i];
			// taps at 15, 2 and 0
			c = {c[14:0], 1'b0} ^ {fb, 12'h000, fb, 1'b0, fb};
		end
		crc_out = c;
	end

endmodule

// ==== source/usb_crc5.sv ====
/*
 * usb crc5, x^5 + x^2 + 1
 * eleven token bits in one step, bit 0 first on the wire
 */
`timescale 1ns/1ns

module usb_crc5 (
	input logic [10:0] data,
	input logic [4:0] crc_in,
	output logic [4:0] crc_out
);

	// serial lfsr unrolled across all eleven bits
	always_comb begin
		logic [4:0] c;
		logic fb;
		c = crc_in;
		for (int i = 0; i < 11; i++) begin
			fb = c[4] ^ data[i];
			c = {c[3:0], 1'b0} ^ {2'b00, fb, 1'b0, fb};
		end
		crc_out = c;
	end

endmodule

// ==== source/usb_packet_top.sv ====
/*
 * usb 2.0 device packet handler top
 * receive path, transmit path and transaction controller
 */
`timescale 1ns/1ns

module usb_packet_top #(
	parameter int MAX_PKT_BYTES = 512,
	parameter int NAK_WAIT = 32
) (
	input logic phy_clk,
	input logic reset_2,
	// ulpi byte stream
	input logic in_act,
	input logic [7:0] in_byte,
	input logic in_latch,
	input logic out_cts,
	input logic out_nxt,
	output logic [7:0] out_byte,
	output logic out_latch,
	output logic out_stp,
	// endpoint side
	output logic [3:0] sel_endp,
	output logic [usb_pkg::BUF_AW-1:0] buf_in_addr,
	output logic [7:0] buf_in_data,
	output logic buf_in_wren,
	input logic buf_in_ready,
	output logic buf_in_commit,
	output logic [usb_pkg::LEN_W-1:0] buf_in_commit_len,
	output logic [usb_pkg::LEN_W-1:0] buf_out_addr,
	input logic [7:0] buf_out_q,
	input logic [usb_pkg::LEN_W-1:0] buf_out_len,
	input logic buf_out_hasdata,
	output logic buf_out_arm,
	output logic data_toggle_act,
	input usb_pkg::toggle_t data_toggle,
	input logic [usb_pkg::ADDR_W-1:0] dev_addr,
	// status
	output logic err_crc_pid,
	output logic err_crc_tok,
	output logic err_crc_pkt,
	output logic [10:0] frame_num
);

	// rx to controller
	logic tok_done, tok_match;
	usb_pkg::pid_t tok_pid, hand_pid;
	logic data_done, crc_ok, hand_done, rx_ready_held;
	logic [usb_pkg::LEN_W-1:0] data_len;
	// controller to tx
	logic tx_start, tx_done;
	usb_pkg::pid_t tx_pid;
	logic [usb_pkg::LEN_W-1:0] tx_len;

	usb_rx #(.MAX_PKT_BYTES(MAX_PKT_BYTES)) u_rx (.*);

	usb_proto_fsm #(.NAK_WAIT(NAK_WAIT)) u_fsm (.*);

	usb_tx u_tx (.*);

endmodule

// ==== source/usb_pkg.sv ====
/*
 * shared definitions for the usb device packet handler
 *  - bus widths and crc seeds
 *  - pid codes and packet kind classes
 *  - token payload union, address/endpoint view and frame view
 *  - data toggle selector
 */
package usb_pkg;

	// widths
	localparam int ADDR_W = 7;
	localparam int LEN_W = 11;
	localparam int BUF_AW = 9;

	// both crcs start from all ones
	localparam logic [15:0] CRC16_INIT = 16'hffff;
	localparam logic [4:0] CRC5_INIT = 5'h1f;

	// pid code as seen in the upper nibble of the pid byte
	// lower nibble on the wire is its complement
	typedef enum logic [3:0] {
		PID_OUT = 4'he,
		PID_IN = 4'h6,
		PID_SOF = 4'ha,
		PID_SETUP = 4'h2,
		PID_DATA0 = 4'hc,
		PID_DATA1 = 4'h4,
		PID_DATA2 = 4'h8,
		PID_MDATA = 4'h0,
		PID_ACK = 4'hd,
		PID_NAK = 4'h5
	} pid_t;

	typedef enum logic [1:0] {
		KIND_TOKEN = 2'd0,
		KIND_DATA = 2'd1,
		KIND_HAND = 2'd2,
		KIND_OTHER = 2'd3
	} pkt_kind_t;

	// token payload in receive order, first byte in [15:8]
	// fields go out lsb first, so endpoint and frame straddle the bytes
	typedef union packed {
		struct packed {
			logic endp_lo;
			logic [6:0] addr;
			logic [4:0] crc5;
			logic [2:0] endp_hi;
		} tok;
		struct packed {
			logic [7:0] frame_lo;
			logic [4:0] crc5;
			logic [2:0] frame_hi;
		} sof;
	} token_word_t;

	// selects DATA0/1/2/M for the next IN reply
	typedef enum logic [1:0] {
		TOGGLE_0 = 2'd0,
		TOGGLE_1 = 2'd1,
		TOGGLE_2 = 2'd2,
		TOGGLE_M = 2'd3
	} toggle_t;

endpackage

// ==== source/usb_proto_fsm.sv ====
/*
 * transaction controller
 *  - IN token, wait for buffer data then send data or NAK
 *  - OUT/SETUP data, answer ACK with commit or NAK
 *  - host ACK after IN data, release buffer and flip toggle
 */
`timescale 1ns/1ns

module usb_proto_fsm #(
	parameter int NAK_WAIT = 32
) (
	input logic phy_clk,
	input logic reset_2,
	input logic tok_done,
	input usb_pkg::pid_t tok_pid,
	input logic tok_match,
	input logic data_done,
	input logic crc_ok,
	input logic [usb_pkg::LEN_W-1:0] data_len,
	input logic rx_ready_held,
	input logic hand_done,
	input usb_pkg::pid_t hand_pid,
	input logic buf_out_hasdata,
	input logic [usb_pkg::LEN_W-1:0] buf_out_len,
	input usb_pkg::toggle_t data_toggle,
	input logic tx_done,
	output logic tx_start,
	output usb_pkg::pid_t tx_pid,
	output logic [usb_pkg::LEN_W-1:0] tx_len,
	output logic buf_in_commit,
	output logic [usb_pkg::LEN_W-1:0] buf_in_commit_len,
	output logic buf_out_arm,
	output logic data_toggle_act
);

	localparam int CNT_W = $clog2(NAK_WAIT + 1);
	localparam logic [1:0] P_IDLE = 2'd0;
	localparam logic [1:0] P_IN_WAIT = 2'd1;
	localparam logic [1:0] P_SEND = 2'd2;
	localparam logic [1:0] P_HAND = 2'd3;

	logic [1:0] state;
	logic [CNT_W-1:0] wait_cnt;
	// reply in flight is a data packet
	logic sent_data;
	logic data_ack;
	usb_pkg::pid_t data_pid;

	always_comb begin
		case (data_toggle)
			usb_pkg::TOGGLE_1: data_pid = usb_pkg::PID_DATA1;
			usb_pkg::TOGGLE_2: data_pid = usb_pkg::PID_DATA2;
			usb_pkg::TOGGLE_M: data_pid = usb_pkg::PID_MDATA;
			default: data_pid = usb_pkg::PID_DATA0;
		endcase
	end

	// good OUT/SETUP data while free to answer
	assign data_ack = (state == P_IDLE || state == P_HAND) && data_done && crc_ok;

	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			state <= P_IDLE;
			wait_cnt <= '0;
			sent_data <= 1'b0;
			tx_start <= 1'b0;
			buf_in_commit <= 1'b0;
			buf_out_arm <= 1'b0;
			data_toggle_act <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			buf_in_commit <= 1'b0;
			buf_out_arm <= 1'b0;
			data_toggle_act <= 1'b0;
			case (state)
				P_IDLE, P_HAND: begin
					if (state == P_HAND && hand_done) begin
						state <= P_IDLE;
						if (hand_pid == usb_pkg::PID_ACK) begin
							buf_out_arm <= 1'b1;
							data_toggle_act <= 1'b1;
						end
					end
					// a new token ends any wait for a handshake
					if (tok_done) begin
						state <= P_IDLE;
						if (tok_match && tok_pid == usb_pkg::PID_IN) begin
							state <= P_IN_WAIT;
							wait_cnt <= CNT_W'(NAK_WAIT - 1);
						end
					end
					// bad crc gets silence
					if (data_ack) begin
						tx_start <= 1'b1;
						buf_in_commit <= rx_ready_held;
						sent_data <= 1'b0;
						state <= P_SEND;
					end
				end
				P_IN_WAIT: begin
					if (buf_out_hasdata || wait_cnt == '0) begin
						tx_start <= 1'b1;
						sent_data <= buf_out_hasdata;
						state <= P_SEND;
					end else begin
						wait_cnt <= wait_cnt - CNT_W'(1);
					end
				end
				default: begin
					// hold until stp has gone out
					if (tx_done)
						state <= sent_data ? P_HAND : P_IDLE;
				end
			endcase
		end
	end

	// reply contents, settle with tx_start
	always_ff @(posedge phy_clk) begin
		if (data_ack) begin
			tx_pid <= rx_ready_held ? usb_pkg::PID_ACK : usb_pkg::PID_NAK;
			tx_len <= '0;
			buf_in_commit_len <= data_len;
		end
		if (state == P_IN_WAIT) begin
			tx_pid <= buf_out_hasdata ? data_pid : usb_pkg::PID_NAK;
			tx_len <= buf_out_hasdata ? buf_out_len : '0;
		end
	end

endmodule

// ==== source/usb_rx.sv ====
/*
 * receive side of the packet handler
 *  - pid check and packet classification
 *  - token assembly, crc5 check, endpoint select and sof frame number
 *  - data bytes into the endpoint buffer two bytes late
 *  - crc16 check against the trailing two bytes
 */
`timescale 1ns/1ns

module usb_rx #(
	parameter int MAX_PKT_BYTES = 512
) (
	input logic phy_clk,
	input logic reset_2,
	input logic in_act,
	input logic [7:0] in_byte,
	input logic in_latch,
	input logic [usb_pkg::ADDR_W-1:0] dev_addr,
	input logic buf_in_ready,
	output logic [usb_pkg::BUF_AW-1:0] buf_in_addr,
	output logic [7:0] buf_in_data,
	output logic buf_in_wren,
	output logic tok_done,
	output usb_pkg::pid_t tok_pid,
	output logic tok_match,
	output logic [3:0] sel_endp,
	output logic [10:0] frame_num,
	output logic data_done,
	output logic crc_ok,
	output logic [usb_pkg::LEN_W-1:0] data_len,
	output logic hand_done,
	output usb_pkg::pid_t hand_pid,
	output logic rx_ready_held,
	output logic err_crc_pid,
	output logic err_crc_tok,
	output logic err_crc_pkt
);

	localparam int LEN_W = usb_pkg::LEN_W;
	localparam logic [1:0] RX_IDLE = 2'd0;
	localparam logic [1:0] RX_BODY = 2'd1;
	localparam logic [1:0] RX_SKIP = 2'd2;

	logic [1:0] state;
	usb_pkg::pid_t pid_in, pid_q;
	usb_pkg::pkt_kind_t kind_in, kind_q;
	logic pid_ok;
	logic body_byte;
	logic [LEN_W-1:0] bc;
	logic [LEN_W-1:0] wr_idx;
	logic [7:0] tok_hi;
	usb_pkg::token_word_t tok_next;
	logic [4:0] crc5_calc;
	logic crc5_good;
	logic tok_addr_hit;
	// last good non-sof token
	logic last_match, last_out;
	logic [15:0] crc16, crc16_1, crc16_2, crc16_next;
	logic [15:0] tail;
	logic crc16_good;
	logic [7:0] dly_0, dly_1;

	assign pid_in = usb_pkg::pid_t'(in_byte[7:4]);
	assign pid_ok = in_byte[7:4] == ~in_byte[3:0];
	assign body_byte = (state == RX_BODY) && in_latch;
	assign wr_idx = bc - LEN_W'(2);

	always_comb begin
		case (pid_in)
			usb_pkg::PID_OUT, usb_pkg::PID_IN, usb_pkg::PID_SOF, usb_pkg::PID_SETUP:
				kind_in = usb_pkg::KIND_TOKEN;
			usb_pkg::PID_DATA0, usb_pkg::PID_DATA1, usb_pkg::PID_DATA2, usb_pkg::PID_MDATA:
				kind_in = usb_pkg::KIND_DATA;
			usb_pkg::PID_ACK, usb_pkg::PID_NAK:
				kind_in = usb_pkg::KIND_HAND;
			default:
				kind_in = usb_pkg::KIND_OTHER;
		endcase
	end

	// token seen as if the current byte were the second payload byte
	assign tok_next = {tok_hi, in_byte};
	assign tok_addr_hit = tok_next.tok.addr == dev_addr;

	usb_crc5 u_crc5 (
		.data ({tok_next.sof.frame_hi, tok_next.sof.frame_lo}),
		.crc_in (usb_pkg::CRC5_INIT),
		.crc_out (crc5_calc)
	);

	// wire order is inverted crc, msb first
	assign crc5_good = tok_next.tok.crc5 ==
		~{crc5_calc[0], crc5_calc[1], crc5_calc[2], crc5_calc[3], crc5_calc[4]};

	usb_crc16 u_crc16 (
		.data (in_byte),
		.crc_in (crc16),
		.crc_out (crc16_next)
	);

	// crc16_2 covers everything but the last two bytes
	assign crc16_good = (bc >= LEN_W'(2)) && (tail == ~{<<{crc16_2}});

	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			state <= RX_IDLE;
			kind_q <= usb_pkg::KIND_OTHER;
			tok_done <= 1'b0;
			data_done <= 1'b0;
			hand_done <= 1'b0;
			buf_in_wren <= 1'b0;
			rx_ready_held <= 1'b0;
			last_match <= 1'b0;
			last_out <= 1'b0;
			sel_endp <= 4'h0;
			frame_num <= 11'h000;
			err_crc_pid <= 1'b0;
			err_crc_tok <= 1'b0;
			err_crc_pkt <= 1'b0;
		end else begin
			tok_done <= 1'b0;
			data_done <= 1'b0;
			hand_done <= 1'b0;
			buf_in_wren <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (in_act && in_latch) begin
						if (pid_ok) begin
							state <= RX_BODY;
							kind_q <= kind_in;
							if (kind_in == usb_pkg::KIND_DATA)
								rx_ready_held <= buf_in_ready;
						end else begin
							// bad pid, ignore rest of packet
							err_crc_pid <= 1'b1;
							state <= RX_SKIP;
						end
					end
				end
				RX_BODY: begin
					if (in_latch && kind_q == usb_pkg::KIND_TOKEN && bc == LEN_W'(1)) begin
						if (!crc5_good) begin
							err_crc_tok <= 1'b1;
							last_match <= 1'b0;
							last_out <= 1'b0;
						end else if (pid_q == usb_pkg::PID_SOF) begin
							tok_done <= 1'b1;
							frame_num <= {tok_next.sof.frame_hi, tok_next.sof.frame_lo};
						end else begin
							tok_done <= 1'b1;
							last_match <= tok_addr_hit;
							last_out <= tok_addr_hit &&
								(pid_q == usb_pkg::PID_OUT || pid_q == usb_pkg::PID_SETUP);
							if (tok_addr_hit)
								sel_endp <= {tok_next.tok.endp_hi, tok_next.tok.endp_lo};
						end
					end
					// write byte n once byte n+2 is in
					if (in_latch && kind_q == usb_pkg::KIND_DATA && bc >= LEN_W'(2))
						buf_in_wren <= rx_ready_held && last_match &&
							(wr_idx < LEN_W'(MAX_PKT_BYTES));
					// end of packet
					if (!in_act) begin
						state <= RX_IDLE;
						if (kind_q == usb_pkg::KIND_DATA && last_out) begin
							data_done <= 1'b1;
							last_out <= 1'b0;
							if (!crc16_good)
								err_crc_pkt <= 1'b1;
						end
						if (kind_q == usb_pkg::KIND_HAND)
							hand_done <= 1'b1;
					end
				end
				default: begin
					if (!in_act)
						state <= RX_IDLE;
				end
			endcase
		end
	end

	// byte path, counters and crc history
	always_ff @(posedge phy_clk) begin
		if (state == RX_IDLE && in_act && in_latch && pid_ok) begin
			pid_q <= pid_in;
			bc <= '0;
			crc16 <= usb_pkg::CRC16_INIT;
		end
		if (body_byte) begin
			bc <= bc + LEN_W'(1);
			crc16 <= crc16_next;
			crc16_1 <= crc16;
			crc16_2 <= crc16_1;
			tail <= {in_byte, tail[15:8]};
			if (bc == '0)
				tok_hi <= in_byte;
			tok_pid <= pid_q;
			tok_match <= tok_addr_hit;
			// two byte delay line
			dly_1 <= in_byte;
			dly_0 <= dly_1;
			buf_in_data <= dly_0;
			buf_in_addr <= wr_idx[usb_pkg::BUF_AW-1:0];
		end
		if (state == RX_BODY && !in_act) begin
			crc_ok <= crc16_good;
			data_len <= bc - LEN_W'(2);
			hand_pid <= pid_q;
		end
	end

endmodule

// ==== source/usb_tx.sv ====
/*
 * transmit side of the packet handler
 *  - ulpi transmit command with the pid
 *  - payload straight from the endpoint buffer, address prefetched
 *  - crc16 low and high bytes, then stp
 */
`timescale 1ns/1ns

module usb_tx (
	input logic phy_clk,
	input logic reset_2,
	input logic tx_start,
	input usb_pkg::pid_t tx_pid,
	input logic [usb_pkg::LEN_W-1:0] tx_len,
	input logic out_cts,
	input logic out_nxt,
	input logic [7:0] buf_out_q,
	output logic [7:0] out_byte,
	output logic out_latch,
	output logic out_stp,
	output logic [usb_pkg::LEN_W-1:0] buf_out_addr,
	output logic tx_done
);

	localparam int LEN_W = usb_pkg::LEN_W;
	localparam logic [2:0] TX_IDLE = 3'd0;
	localparam logic [2:0] TX_CTS = 3'd1;
	localparam logic [2:0] TX_CMD = 3'd2;
	localparam logic [2:0] TX_PAY = 3'd3;
	localparam logic [2:0] TX_CRC_LO = 3'd4;
	localparam logic [2:0] TX_CRC_HI = 3'd5;
	localparam logic [2:0] TX_STOP = 3'd6;

	logic [2:0] state;
	usb_pkg::pid_t pid_q;
	logic [LEN_W-1:0] len_q;
	logic [LEN_W-1:0] rd_idx;
	// data pids carry a crc, handshakes do not
	logic has_crc;
	logic last_pay;
	logic [15:0] crc, crc_next, crc_tx;

	assign last_pay = rd_idx == len_q - LEN_W'(1);
	assign crc_tx = ~{<<{crc}};

	// look one byte ahead when the phy takes the current one
	assign buf_out_addr = rd_idx + LEN_W'(state == TX_PAY && out_nxt);

	always_comb begin
		case (state)
			TX_CMD: out_byte = {4'h4, ~4'(pid_q)};
			TX_PAY: out_byte = buf_out_q;
			TX_CRC_LO: out_byte = crc_tx[7:0];
			TX_CRC_HI: out_byte = crc_tx[15:8];
			default: out_byte = 8'h00;
		endcase
	end

	usb_crc16 u_crc16 (
		.data (buf_out_q),
		.crc_in (crc),
		.crc_out (crc_next)
	);

	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			state <= TX_IDLE;
			out_latch <= 1'b0;
			out_stp <= 1'b0;
			tx_done <= 1'b0;
			rd_idx <= '0;
		end else begin
			out_stp <= 1'b0;
			tx_done <= 1'b0;
			case (state)
				TX_IDLE: begin
					if (tx_start) begin
						state <= TX_CTS;
						rd_idx <= '0;
					end
				end
				TX_CTS: begin
					// bus must be free before the command
					if (out_cts) begin
						state <= TX_CMD;
						out_latch <= 1'b1;
					end
				end
				TX_CMD: begin
					if (out_nxt) begin
						if (!has_crc) begin
							out_stp <= 1'b1;
							out_latch <= 1'b0;
							state <= TX_STOP;
						end else if (len_q == '0) begin
							state <= TX_CRC_LO;
						end else begin
							state <= TX_PAY;
						end
					end
				end
				TX_PAY: begin
					if (out_nxt) begin
						rd_idx <= rd_idx + LEN_W'(1);
						if (last_pay)
							state <= TX_CRC_LO;
					end
				end
				TX_CRC_LO: begin
					if (out_nxt)
						state <= TX_CRC_HI;
				end
				TX_CRC_HI: begin
					if (out_nxt) begin
						out_stp <= 1'b1;
						out_latch <= 1'b0;
						state <= TX_STOP;
					end
				end
				default: begin
					// stp cycle done
					tx_done <= 1'b1;
					state <= TX_IDLE;
				end
			endcase
		end
	end

	// request and crc accumulator
	always_ff @(posedge phy_clk) begin
		if (state == TX_IDLE && tx_start) begin
			pid_q <= tx_pid;
			len_q <= tx_len;
			has_crc <= tx_pid inside {usb_pkg::PID_DATA0, usb_pkg::PID_DATA1,
				usb_pkg::PID_DATA2, usb_pkg::PID_MDATA};
			crc <= usb_pkg::CRC16_INIT;
		end
		if (state == TX_PAY && out_nxt)
			crc <= crc_next;
	end

endmodule
